// ==== build.f ====
hdl/traceFramePkg.sv
hdl/traceDecoder.sv
hdl/frameAssembler.sv
hdl/axiBurstWriter.sv
hdl/traceFramer.sv
verif/traceFramerTb.sv

// ==== hdl/axiBurstWriter.sv ====
//////////////////////////////////////////////////
// axi burst writer
// queues frame beats and drives the AXI4 W channel,
// returns a credit per handshake and counts frames
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module axiBurstWriter #(
  parameter int unsigned beatFifoDepth = 4
) (
  input  logic                    m_axi_aclk,
  input  logic                    m_axi_aresetn,
  input  traceFramePkg::frameBeat beat,
  input  logic                    beatValid,
  input  logic                    wReady,
  output logic                    beatCredit,
  output logic [31:0]             wData,
  output logic [3:0]              wStrb,
  output logic                    wLast,
  output logic                    wValid,
  output logic [31:0]             frameCount
);

  localparam int unsigned ptrW   = (beatFifoDepth > 1) ? $clog2(beatFifoDepth) : 1;
  localparam int unsigned countW = $clog2(beatFifoDepth + 1);

  traceFramePkg::frameBeat fifoMem [beatFifoDepth];
  logic [ptrW-1:0]         wrPtr;
  logic [ptrW-1:0]         rdPtr;
  logic [countW-1:0]       fill;
  logic                    pop;
  traceFramePkg::frameBeat head;

  //////////////////////////////////////////////////
  // beat fifo
  //////////////////////////////////////////////////

  always_ff @(posedge m_axi_aclk) begin
    if (beatValid) begin
      fifoMem[wrPtr] <= beat;
    end
  end

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      wrPtr <= '0;
      rdPtr <= '0;
      fill  <= '0;
    end else begin
      if (beatValid) begin
        wrPtr <= (wrPtr == ptrW'(beatFifoDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (pop) begin
        rdPtr <= (rdPtr == ptrW'(beatFifoDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      fill <= fill + countW'(beatValid) - countW'(pop);
    end
  end

  //////////////////////////////////////////////////
  // W channel
  //////////////////////////////////////////////////

  // head of the fifo is held until the handshake
  assign head   = fifoMem[rdPtr];
  assign wValid = (fill != '0);
  assign wData  = head.data;
  assign wLast  = head.last;
  // full words only
  assign wStrb  = 4'hf;

  assign pop        = wValid && wReady;
  assign beatCredit = pop;

  // completed frames, one per wLast handshake
  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      frameCount <= 32'd0;
    end else if (pop && wLast) begin
      frameCount <= frameCount + 32'd1;
    end
  end

  // assembler beat credits match the free fifo slots
  noFifoOverflow: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    beatValid |-> (fill < countW'(beatFifoDepth)));

  // AXI rule, a stalled beat holds until taken
  wHold: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    (wValid && !wReady) |=> (wValid && $stable(wData) && $stable(wLast)));

endmodule

`default_nettype wire

// ==== hdl/frameAssembler.sv ====
//////////////////////////////////////////////////
// frame assembler
// buffers decoded records, waits out the link
// hold-off after reset and then lays each record
// out as a nine-word frame, one beat per credit
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module frameAssembler #(
  parameter int unsigned recordDepth   = 2,
  parameter int unsigned beatFifoDepth = 4,
  parameter int unsigned initTimeout   = 16
) (
  input  logic                      m_axi_aclk,
  input  logic                      m_axi_aresetn,
  input  traceFramePkg::traceRecord rec,
  input  logic                      recValid,
  input  logic                      beatCredit,
  output logic                      recCredit,
  output traceFramePkg::frameBeat   beat,
  output logic                      beatValid
);

  localparam int unsigned ptrW    = (recordDepth > 1) ? $clog2(recordDepth) : 1;
  localparam int unsigned countW  = $clog2(recordDepth + 1);
  localparam int unsigned creditW = $clog2(beatFifoDepth + 1);
  localparam int unsigned holdW   = (initTimeout > 1) ? $clog2(initTimeout) : 1;
  localparam logic [3:0]  lastIdx = 4'(traceFramePkg::frameWords - 1);

  traceFramePkg::traceRecord recBuf [recordDepth];
  logic [ptrW-1:0]           wrPtr;
  logic [ptrW-1:0]           rdPtr;
  logic [countW-1:0]         recCount;
  traceFramePkg::asmState    state;
  traceFramePkg::asmState    nextState;
  logic [holdW-1:0]          holdCnt;
  logic                      holdDone;
  logic [3:0]                beatIdx;
  logic [creditW-1:0]        beatCredits;
  logic                      lastBeat;
  traceFramePkg::traceRecord head;

  //////////////////////////////////////////////////
  // record buffer
  //////////////////////////////////////////////////

  // decoder credits guarantee a free slot on every recValid
  always_ff @(posedge m_axi_aclk) begin
    if (recValid) begin
      recBuf[wrPtr] <= rec;
    end
  end

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      wrPtr    <= '0;
      rdPtr    <= '0;
      recCount <= '0;
    end else begin
      if (recValid) begin
        wrPtr <= (wrPtr == ptrW'(recordDepth - 1)) ? '0 : wrPtr + 1'b1;
      end
      // slot frees with the last beat of its frame
      if (recCredit) begin
        rdPtr <= (rdPtr == ptrW'(recordDepth - 1)) ? '0 : rdPtr + 1'b1;
      end
      recCount <= recCount + countW'(recValid) - countW'(recCredit);
    end
  end

  assign head = recBuf[rdPtr];

  //////////////////////////////////////////////////
  // state machine and hold-off
  //////////////////////////////////////////////////

  assign holdDone = (holdCnt == holdW'(initTimeout - 1));

  always_comb begin
    nextState = state;
    case (state)
      traceFramePkg::stReset: nextState = traceFramePkg::stHoldoff;
      traceFramePkg::stHoldoff: begin
        if (holdDone) begin
          nextState = traceFramePkg::stIdle;
        end
      end
      traceFramePkg::stIdle: begin
        if (recCount != '0) begin
          nextState = traceFramePkg::stSend;
        end
      end
      traceFramePkg::stSend: begin
        // stay for a back-to-back frame if another record waits
        if (recCredit && (recCount == countW'(1))) begin
          nextState = traceFramePkg::stIdle;
        end
      end
      default: nextState = traceFramePkg::stReset;
    endcase
  end

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      state   <= traceFramePkg::stReset;
      holdCnt <= '0;
    end else begin
      state <= nextState;
      // counts only while holding off, cleared otherwise
      if (state == traceFramePkg::stHoldoff) begin
        holdCnt <= holdCnt + 1'b1;
      end else begin
        holdCnt <= '0;
      end
    end
  end

  //////////////////////////////////////////////////
  // beat sequencing
  //////////////////////////////////////////////////

  assign beatValid = (state == traceFramePkg::stSend) && (beatCredits != '0);
  assign lastBeat  = (beatIdx == lastIdx);
  assign recCredit = beatValid && lastBeat;

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      beatIdx     <= 4'd0;
      beatCredits <= creditW'(beatFifoDepth);
    end else begin
      if (beatValid) begin
        beatIdx <= lastBeat ? 4'd0 : beatIdx + 4'd1;
      end
      // writer returns one credit per W handshake
      beatCredits <= beatCredits + creditW'(beatCredit) - creditW'(beatValid);
    end
  end

  // header words first, then the record of the buffer head
  always_comb begin
    beat.last = lastBeat;
    case (beatIdx)
      4'd0: beat.data = traceFramePkg::dstMac[47:16];
      4'd1: beat.data = {traceFramePkg::dstMac[15:0], traceFramePkg::srcMac[47:32]};
      4'd2: beat.data = traceFramePkg::srcMac[31:0];
      4'd3: beat.data = {traceFramePkg::ethType, traceFramePkg::payloadBytes};
      4'd4: beat.data = head.pc;
      4'd5: beat.data = head.instr;
      4'd6: beat.data = head.rdValue;
      4'd7: beat.data = head.memAddr;
      4'd8: beat.data = {head.seqNum, head.cls, head.rd, head.writesRd, 6'd0};
      default: beat.data = 32'd0;
    endcase
  end

  // decoder credits keep the buffer from overrunning
  noOverrun: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    recValid |-> (recCount < countW'(recordDepth)));

  // link partner is still coming up, the hold-off runs its full length
  // before the first frame may start
  quietHoldoff: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    ((state != traceFramePkg::stHoldoff) && $past(state == traceFramePkg::stHoldoff))
      |-> $past(state == traceFramePkg::stHoldoff, initTimeout));

endmodule

`default_nettype wire

// ==== hdl/traceDecoder.sv ====
//////////////////////////////////////////////////
// trace decoder
// classifies each retirement by major opcode,
// clears fields that do not apply to the class and
// stamps a sequence number; also holds the credits
// toward the frame assembler record buffer
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module traceDecoder #(
  parameter int unsigned recordDepth = 2
) (
  input  logic                      m_axi_aclk,
  input  logic                      m_axi_aresetn,
  input  traceFramePkg::retireInfo  retire,
  input  logic                      retireValid,
  input  logic                      recCredit,
  output logic                      traceStall,
  output traceFramePkg::traceRecord rec,
  output logic                      recValid
);

  localparam int unsigned creditW = $clog2(recordDepth + 1);

  logic [creditW-1:0]        credits;
  logic                      linkUp;
  logic                      accept;
  logic [15:0]               seqNum;
  traceFramePkg::opClass     cls;
  logic [4:0]                rd;
  logic                      writesRd;
  logic                      memOp;
  traceFramePkg::traceRecord decoded;

  //////////////////////////////////////////////////
  // classification
  //////////////////////////////////////////////////

  // major opcode sits in instr[6:0]
  always_comb begin
    case (retire.instr[6:0])
      7'b0000011: cls = traceFramePkg::opLoad;
      7'b0100011: cls = traceFramePkg::opStore;
      7'b1100011: cls = traceFramePkg::opBranch;
      // jal and jalr
      7'b1101111,
      7'b1100111: cls = traceFramePkg::opJump;
      // op, op-imm, lui, auipc
      7'b0110011,
      7'b0010011,
      7'b0110111,
      7'b0010111: cls = traceFramePkg::opAlu;
      7'b1110011: cls = traceFramePkg::opSystem;
      default:    cls = traceFramePkg::opOther;
    endcase
  end

  assign rd = retire.instr[11:7];

  // x0 writes are dropped, only these classes write rd
  assign writesRd = (rd != 5'd0) &&
                    ((cls == traceFramePkg::opLoad) ||
                     (cls == traceFramePkg::opJump) ||
                     (cls == traceFramePkg::opAlu));

  assign memOp = (cls == traceFramePkg::opLoad) || (cls == traceFramePkg::opStore);

  // masked record, stamped with the running sequence number
  always_comb begin
    decoded.pc       = retire.pc;
    decoded.instr    = retire.instr;
    decoded.rdValue  = writesRd ? retire.rdValue : 32'd0;
    decoded.memAddr  = memOp ? retire.memAddr : 32'd0;
    decoded.seqNum   = seqNum;
    decoded.cls      = cls;
    decoded.rd       = rd;
    decoded.writesRd = writesRd;
    decoded.rsvd     = 6'd0;
  end

  //////////////////////////////////////////////////
  // credits and output register
  //////////////////////////////////////////////////

  // stall while credits are gone, and until the first edge after reset
  assign traceStall = !linkUp || (credits == '0);
  assign accept     = retireValid && !traceStall;

  always_ff @(posedge m_axi_aclk) begin
    if (!m_axi_aresetn) begin
      credits  <= creditW'(recordDepth);
      linkUp   <= 1'b0;
      seqNum   <= 16'd0;
      recValid <= 1'b0;
    end else begin
      linkUp   <= 1'b1;
      // one back per freed slot, one spent per accept
      credits  <= credits + creditW'(recCredit) - creditW'(accept);
      recValid <= accept;
      if (accept) begin
        seqNum <= seqNum + 16'd1;
      end
    end
  end

  // payload only, recValid qualifies it
  always_ff @(posedge m_axi_aclk) begin
    if (accept) begin
      rec <= decoded;
    end
  end

  // credits stay within the assembler buffer size, a wrap shows up here too
  creditBound: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    credits <= creditW'(recordDepth));

  // the assembler only frees slots that hold a record
  creditReturn: assert property (@(posedge m_axi_aclk) disable iff (!m_axi_aresetn)
    recCredit |-> (credits < creditW'(recordDepth)));

endmodule

`default_nettype wire

// ==== hdl/traceFramePkg.sv ====
//////////////////////////////////////////////////
// trace framer shared definitions
// frame constants, opcode classes and the records
// passed between decode, assembly and the writer
//////////////////////////////////////////////////
`default_nettype none

package traceFramePkg;

  //////////////////////////////////////////////////
  // frame constants
  //////////////////////////////////////////////////

  // locally administered addresses for the trace link
  localparam logic [47:0] dstMac = 48'h0254_5243_0001;
  localparam logic [47:0] srcMac = 48'h0254_5243_0002;

  // local experimental ethertype
  localparam logic [15:0] ethType = 16'h88b5;

  // four header words plus five payload words
  localparam int unsigned frameWords = 9;

  // payload length carried in the header length field
  localparam logic [15:0] payloadBytes = 16'd20;

  //////////////////////////////////////////////////
  // opcode classes and assembler states
  //////////////////////////////////////////////////

  // major opcode classes, encoding lands in the frame
  typedef enum logic [3:0] {
    opOther  = 4'd0,
    opLoad   = 4'd1,
    opStore  = 4'd2,
    opBranch = 4'd3,
    opJump   = 4'd4,
    opAlu    = 4'd5,
    opSystem = 4'd6
  } opClass;

  // frame assembler control states
  typedef enum logic [1:0] {
    stReset,
    stHoldoff,
    stIdle,
    stSend
  } asmState;

  //////////////////////////////////////////////////
  // stage records
  //////////////////////////////////////////////////

  // one retirement as presented by the core
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] rdValue;
    logic [31:0] memAddr;
  } retireInfo;

  // normalized record, 160 bits
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] rdValue;
    logic [31:0] memAddr;
    logic [15:0] seqNum;
    opClass      cls;
    logic [4:0]  rd;
    logic        writesRd;
    // always zero, pads the last payload word
    logic [5:0]  rsvd;
  } traceRecord;

  // one 32-bit beat of a frame
  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } frameBeat;

endpackage

`default_nettype wire

// ==== hdl/traceFramer.sv ====
//////////////////////////////////////////////////
// trace framer top
// decode, frame assembly and AXI4 W-channel burst
// stages, linked by credit-based flow control
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module traceFramer #(
  parameter int unsigned recordDepth   = 2,
  parameter int unsigned beatFifoDepth = 4,
  parameter int unsigned initTimeout   = 16
) (
  input  logic                     m_axi_aclk,
  input  logic                     m_axi_aresetn,
  // core retirement port
  input  traceFramePkg::retireInfo retire,
  input  logic                     retireValid,
  output logic                     traceStall,
  // axi4 write data channel toward the MAC
  output logic [31:0]              wData,
  output logic [3:0]               wStrb,
  output logic                     wLast,
  output logic                     wValid,
  input  logic                     wReady,
  output logic [31:0]              frameCount
);

  // decode to execute
  traceFramePkg::traceRecord rec;
  logic                      recValid;
  logic                      recCredit;

  // execute to result
  traceFramePkg::frameBeat   beat;
  logic                      beatValid;
  logic                      beatCredit;

  traceDecoder #(
    .recordDepth (recordDepth)
  ) decoderInst (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .retire        (retire),
    .retireValid   (retireValid),
    .recCredit     (recCredit),
    .traceStall    (traceStall),
    .rec           (rec),
    .recValid      (recValid)
  );

  frameAssembler #(
    .recordDepth   (recordDepth),
    .beatFifoDepth (beatFifoDepth),
    .initTimeout   (initTimeout)
  ) assemblerInst (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .rec           (rec),
    .recValid      (recValid),
    .beatCredit    (beatCredit),
    .recCredit     (recCredit),
    .beat          (beat),
    .beatValid     (beatValid)
  );

  axiBurstWriter #(
    .beatFifoDepth (beatFifoDepth)
  ) writerInst (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .beat          (beat),
    .beatValid     (beatValid),
    .wReady        (wReady),
    .beatCredit    (beatCredit),
    .wData         (wData),
    .wStrb         (wStrb),
    .wLast         (wLast),
    .wValid        (wValid),
    .frameCount    (frameCount)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# build and run the trace framer testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing -Wno-fatal -f build.f --top-module traceFramerTb \
  -o simv > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/simv > sim.log 2>&1 || true
cat sim.log
grep -q "test failed" sim.log && exit 1
grep -q "test passed" sim.log || exit 1
exit 0

// ==== verif/traceFramerTb.sv ====
//////////////////////////////////////////////////
// trace framer testbench
// random retirements against a frame reference
// model, with random W-channel back-pressure
//////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module traceFramerTb;

  localparam int unsigned initTimeout   = 16;
  localparam int unsigned numFrames     = 60;
  localparam int unsigned frameWords    = 9;
  // hold-off, worst case six cycles per beat, plus slack
  localparam int unsigned timeoutCycles = initTimeout + numFrames * frameWords * 6 + 200;

  logic                     m_axi_aclk;
  logic                     m_axi_aresetn;
  traceFramePkg::retireInfo retire;
  logic                     retireValid;
  logic                     traceStall;
  logic [31:0]              wData;
  logic [3:0]               wStrb;
  logic                     wLast;
  logic                     wValid;
  logic                     wReady;
  logic [31:0]              frameCount;

  // reference model and bookkeeping
  logic [31:0]  expWords [$];
  logic [31:0]  rngState;
  logic [15:0]  expSeq;
  int unsigned  acceptCount;
  int unsigned  lastsSeen;
  int unsigned  beatPos;
  int unsigned  cycleCount;
  int unsigned  resetEdges;
  int unsigned  sinceRelease;
  logic         stallSeen;
  logic         holdPending;
  logic [31:0]  heldData;
  logic         heldLast;

  traceFramer traceFramer_inst (
    .m_axi_aclk    (m_axi_aclk),
    .m_axi_aresetn (m_axi_aresetn),
    .retire        (retire),
    .retireValid   (retireValid),
    .traceStall    (traceStall),
    .wData         (wData),
    .wStrb         (wStrb),
    .wLast         (wLast),
    .wValid        (wValid),
    .wReady        (wReady),
    .frameCount    (frameCount)
  );

  initial begin
    m_axi_aclk = 1'b0;
    forever #50 m_axi_aclk = ~m_axi_aclk;
  end

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  task automatic stopOnError(input string what);
    $display("%s", what);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic reportMismatch(input string check, input logic [31:0] want,
                                input logic [31:0] got);
    stopOnError($sformatf("ERROR %s: expected %h actual %h", check, want, got));
  endtask

  // numerical recipes constants, upper bits are the useful ones
  function automatic logic [31:0] nextRand();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  // every class once, jump and alu in all forms, plus one undefined opcode
  function automatic logic [6:0] opcodeFor(input int unsigned idx);
    case (idx)
      0:       return 7'b0000011;
      1:       return 7'b0100011;
      2:       return 7'b1100011;
      3:       return 7'b1101111;
      4:       return 7'b1100111;
      5:       return 7'b0110011;
      6:       return 7'b0010011;
      7:       return 7'b0110111;
      8:       return 7'b0010111;
      9:       return 7'b1110011;
      default: return 7'b1111111;
    endcase
  endfunction

  // expected nine words of the frame for one accepted retirement
  task automatic pushExpectedFrame(input traceFramePkg::retireInfo r,
                                   input logic [15:0] seq);
    logic [3:0]  cls;
    logic [4:0]  rd;
    logic        writes;
    logic [31:0] rdv;
    logic [31:0] mem;
    case (r.instr[6:0])
      7'b0000011: cls = 4'd1;
      7'b0100011: cls = 4'd2;
      7'b1100011: cls = 4'd3;
      7'b1101111, 7'b1100111: cls = 4'd4;
      7'b0110011, 7'b0010011, 7'b0110111, 7'b0010111: cls = 4'd5;
      7'b1110011: cls = 4'd6;
      default:    cls = 4'd0;
    endcase
    rd     = r.instr[11:7];
    writes = (rd != 5'd0) && ((cls == 4'd1) || (cls == 4'd4) || (cls == 4'd5));
    rdv    = writes ? r.rdValue : 32'd0;
    mem    = ((cls == 4'd1) || (cls == 4'd2)) ? r.memAddr : 32'd0;
    // header
    expWords.push_back(traceFramePkg::dstMac[47:16]);
    expWords.push_back({traceFramePkg::dstMac[15:0], traceFramePkg::srcMac[47:32]});
    expWords.push_back(traceFramePkg::srcMac[31:0]);
    expWords.push_back({traceFramePkg::ethType, traceFramePkg::payloadBytes});
    // payload
    expWords.push_back(r.pc);
    expWords.push_back(r.instr);
    expWords.push_back(rdv);
    expWords.push_back(mem);
    expWords.push_back({seq, cls, rd, writes, 6'd0});
  endtask

  // one cycle of random retirement and wReady
  task automatic driveInputs();
    logic [31:0] r;
    logic [31:0] ins;
    logic [4:0]  rd;
    r = nextRand();
    // mostly continuous so the record buffer backs up
    retireValid = (acceptCount < numFrames) && (r[31:29] != 3'd0);
    r = nextRand();
    // about 70 percent ready
    wReady = (r[31:16] % 16'd10) < 16'd7;
    r = nextRand();
    rd = (r[31:30] == 2'd0) ? 5'd0 : r[20:16];
    ins = nextRand();
    retire.instr   = {ins[31:12], rd, opcodeFor(int'(r[27:24]) % 11)};
    retire.pc      = nextRand();
    retire.rdValue = nextRand();
    retire.memAddr = nextRand();
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    rngState      = 32'h14e2;
    m_axi_aresetn = 1'b0;
    retire        = '0;
    retireValid   = 1'b0;
    wReady        = 1'b0;
    repeat (10) @(posedge m_axi_aclk);
    #1 m_axi_aresetn = 1'b1;
    driveInputs();
    while (lastsSeen < numFrames) begin
      @(posedge m_axi_aclk);
      #1 driveInputs();
    end
    // drain window, a duplicated beat would show up here
    retireValid = 1'b0;
    wReady      = 1'b1;
    repeat (30) @(posedge m_axi_aclk);
    if (expWords.size() != 0) begin
      stopOnError($sformatf("%0d expected words never arrived", expWords.size()));
    end else if (!stallSeen) begin
      stopOnError("traceStall never rose under back-pressure");
    end else begin
      $display("test passed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // monitor, samples pre-edge values
  //////////////////////////////////////////////////

  initial begin
    expSeq       = 16'd0;
    acceptCount  = 0;
    lastsSeen    = 0;
    beatPos      = 0;
    cycleCount   = 0;
    resetEdges   = 0;
    sinceRelease = 0;
    stallSeen    = 1'b0;
    holdPending  = 1'b0;
    heldData     = 32'd0;
    heldLast     = 1'b0;
  end

  always @(posedge m_axi_aclk) begin
    logic [31:0] want;
    cycleCount = cycleCount + 1;
    if (cycleCount >= timeoutCycles) begin
      stopOnError($sformatf("timeout, only %0d of %0d frames after %0d cycles",
                            lastsSeen, numFrames, cycleCount));
    end
    if (!m_axi_aresetn) begin
      // regs are defined once one reset edge has passed
      if (resetEdges > 0) begin
        assert (traceStall && !wValid)
          else stopOnError("traceStall low or wValid high during reset");
      end
      resetEdges = resetEdges + 1;
    end else begin
      sinceRelease = sinceRelease + 1;
      if (sinceRelease == 2) begin
        assert (!traceStall) else reportMismatch("resetStall", 32'd0, 32'(traceStall));
        assert (frameCount == 32'd0) else reportMismatch("resetCount", 32'd0, frameCount);
      end
      // link partner still coming up
      if (sinceRelease <= initTimeout) begin
        assert (!wValid) else stopOnError("wValid rose inside the hold-off window");
      end
      if (traceStall && (sinceRelease >= 2)) begin
        stallSeen = 1'b1;
      end
      assert (frameCount == 32'(lastsSeen))
        else reportMismatch("frameCount", 32'(lastsSeen), frameCount);
      // a stalled beat must still be there, unchanged
      if (holdPending) begin
        assert (wValid && (wData == heldData) && (wLast == heldLast))
          else stopOnError("W beat dropped or changed while wReady was low");
      end
      holdPending = wValid && !wReady;
      heldData    = wData;
      heldLast    = wLast;
      if (wValid) begin
        assert (wStrb == 4'hf) else reportMismatch("wStrb", 32'hf, 32'(wStrb));
      end
      if (wValid && wReady) begin
        if (expWords.size() == 0) begin
          stopOnError("W beat transferred with no frame expected");
        end else begin
          want = expWords.pop_front();
          assert (wData == want)
            else reportMismatch((beatPos < 4) ? "header" : "payload", want, wData);
          assert (wLast == (beatPos == frameWords - 1))
            else reportMismatch("wLast", 32'(beatPos == frameWords - 1), 32'(wLast));
          if (wLast) begin
            lastsSeen = lastsSeen + 1;
          end
          beatPos = (beatPos == frameWords - 1) ? 0 : beatPos + 1;
        end
      end
      // accepted retirement becomes one expected frame
      if (retireValid && !traceStall) begin
        pushExpectedFrame(retire, expSeq);
        expSeq      = expSeq + 16'd1;
        acceptCount = acceptCount + 1;
      end
    end
  end

endmodule

`default_nettype wire
